/* common/vec_defines.svh */
`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

// vector register width in bits
`define VLEN 128
// datapath beat, one half of a register
`define DATA_WIDTH 64
`define DW_B 8
`define BEATS_PER_REG 2

// register file shape
`define NUM_VEC 32
`define VREG_ADDR_WIDTH 5

// host side widths
`define XLEN 32
`define INSN_WIDTH 32
`define MEM_ADDR_WIDTH 32

`endif

/* common/rvv_isa_pkg.sv */
`include "vec_defines.svh"

package rvv_isa_pkg;

    // major opcodes, insn[6:0]
    typedef enum logic [6:0] {
        ST_OP = 7'h27,
        V_OP  = 7'h57
    } opcode_mjr_e;

    // funct3 of OP-V, operand category
    typedef enum logic [2:0] {
        IVV = 3'h0,
        IVI = 3'h3,
        IVX = 3'h4,
        CFG = 3'h7
    } opcode_mnr_e;

    // funct6 of the integer ops kept here
    typedef enum logic [5:0] {
        VADD = 6'h00,
        VSUB = 6'h02,
        VAND = 6'h09,
        VOR  = 6'h0A,
        VXOR = 6'h0B
    } alu_funct_e;

    // what the issue block does with a fetched insn
    typedef enum logic [1:0] {
        CLS_NONE,
        CLS_CFG,
        CLS_ALU,
        CLS_STORE
    } insn_class_e;

    typedef struct packed {
        insn_class_e                  cls;
        opcode_mnr_e                  mnr;
        alu_funct_e                   funct;
        // vd for alu ops, vs3 for stores
        logic [`VREG_ADDR_WIDTH-1:0]  vd;
        // vs1, rs1 or simm5
        logic [`VREG_ADDR_WIDTH-1:0]  vs1;
        logic [`VREG_ADDR_WIDTH-1:0]  vs2;
        // vsew from the vsetvli zimm
        logic [2:0]                   sew;
    } decoded_insn_t;

endpackage

/* common/vec_pipe_pkg.sv */
`include "vec_defines.svh"

package vec_pipe_pkg;

    // beat offset inside a register
    localparam int OFF_WIDTH = $clog2(`BEATS_PER_REG);

    typedef struct packed {
        logic [2:0] sew;
        logic [7:0] vl;
    } vcfg_t;

    // one beat headed into the alu
    typedef struct packed {
        logic                         valid;
        rvv_isa_pkg::alu_funct_e      funct;
        logic [2:0]                   sew;
        logic [`VREG_ADDR_WIDTH-1:0]  vd;
        logic [OFF_WIDTH-1:0]         off;
        logic                         use_scalar;
        // scalar or imm already replicated per element
        logic [`DATA_WIDTH-1:0]       scalar;
    } alu_beat_t;

    // alu result beat, goes to the regfile write port
    typedef struct packed {
        logic                         valid;
        logic [`VREG_ADDR_WIDTH-1:0]  vd;
        logic [OFF_WIDTH-1:0]         off;
        logic [`DATA_WIDTH-1:0]       data;
    } wr_beat_t;

endpackage

/* src/insn_decoder.sv */
`timescale 1ns/1ps
`include "vec_defines.svh"

module insn_decoder
    import rvv_isa_pkg::*;
(
    input  logic [`INSN_WIDTH-1:0] insn,
    output decoded_insn_t          dec
);

    opcode_mjr_e mjr;
    logic        funct_ok;

    assign mjr      = opcode_mjr_e'(insn[6:0]);
    assign funct_ok = alu_funct_e'(insn[31:26]) inside {VADD, VSUB, VAND, VOR, VXOR};

    always_comb begin
        dec       = '0;
        // field slicing, meaning depends on class
        dec.mnr   = opcode_mnr_e'(insn[14:12]);
        dec.funct = alu_funct_e'(insn[31:26]);
        dec.vd    = insn[11:7];
        dec.vs1   = insn[19:15];
        dec.vs2   = insn[24:20];
        // vsew sits at zimm[5:3]
        dec.sew   = insn[25:23];
        dec.cls   = CLS_NONE;
        case (mjr)
            V_OP: begin
                case (dec.mnr)
                    // unmasked only, vm must be set
                    IVV, IVI, IVX: if (insn[25] && funct_ok) dec.cls = CLS_ALU;
                    // vsetvli only, sew above 64 is rejected here
                    CFG: if (!insn[31] && !insn[25]) dec.cls = CLS_CFG;
                    default: dec.cls = CLS_NONE;
                endcase
            end
            ST_OP: begin
                // unit stride: nf, mew, mop and sumop all zero, vm set
                if (insn[31:26] == 6'h0 && insn[25] && insn[24:20] == 5'h0) begin
                    dec.cls = CLS_STORE;
                end
            end
            default: dec.cls = CLS_NONE;
        endcase
    end

endmodule

/* src/cfg_unit.sv */
`timescale 1ns/1ps
`include "vec_defines.svh"

module cfg_unit
    import rvv_isa_pkg::*, vec_pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  decoded_insn_t      dec,
    input  logic               fire,
    input  logic [`XLEN-1:0]   avl,
    output vcfg_t              cfg,
    output logic               vl_report_valid,
    output logic [`XLEN-1:0]   vl_report
);

    logic       is_cfg;
    logic [7:0] vlmax;
    logic [7:0] vl_next;

    assign is_cfg = fire && dec.cls == CLS_CFG;

    // elements per register, lmul fixed at 1
    assign vlmax = 8'((`VLEN / 8) >> dec.sew);

    // rs1 = x0 asks for vlmax, else clip avl
    assign vl_next = (dec.vs1 == '0)             ? vlmax :
                     (avl < `XLEN'(vlmax))       ? avl[7:0] : vlmax;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.sew <= 3'd0;
            cfg.vl  <= 8'd0;
        end else if (is_cfg) begin
            cfg.sew <= dec.sew;
            cfg.vl  <= vl_next;
        end
    end

    // report goes back in the issue cycle
    assign vl_report_valid = is_cfg;
    assign vl_report       = `XLEN'(vl_next);

    // decoder keeps illegal vsew out, alu lane split relies on it
    a_sew_legal: assert property (@(posedge clk) disable iff (!rst_n) cfg.sew <= 3'd3);

endmodule

/* vec_exec/vec_regfile.sv */
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_regfile
    import vec_pipe_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`VREG_ADDR_WIDTH-1:0]  rd_addr_1,
    input  logic [`VREG_ADDR_WIDTH-1:0]  rd_addr_2,
    input  logic [`VREG_ADDR_WIDTH-1:0]  rd_addr_3,
    input  logic [OFF_WIDTH-1:0]         rd_off,
    output logic [`DATA_WIDTH-1:0]       rd_data_1,
    output logic [`DATA_WIDTH-1:0]       rd_data_2,
    output logic [`DATA_WIDTH-1:0]       rd_data_3,
    input  wr_beat_t                     wr_beat
);

    // one entry per register beat
    logic [`DATA_WIDTH-1:0] regs [`NUM_VEC][`BEATS_PER_REG];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_VEC; r++) begin
                for (int b = 0; b < `BEATS_PER_REG; b++) begin
                    regs[r][b] <= '0;
                end
            end
        end else if (wr_beat.valid) begin
            regs[wr_beat.vd][wr_beat.off] <= wr_beat.data;
        end
    end

    // async reads of vs1 and vs2 for the alu and vs3 for stores
    assign rd_data_1 = regs[rd_addr_1][rd_off];
    assign rd_data_2 = regs[rd_addr_2][rd_off];
    assign rd_data_3 = regs[rd_addr_3][rd_off];

    // upper beat lands one cycle after the lower beat of the same register
    a_wr_order: assert property (@(posedge clk) disable iff (!rst_n)
        wr_beat.valid && wr_beat.off != '0 |->
            $past(wr_beat.valid) && $past(wr_beat.vd) == wr_beat.vd
            && $past(wr_beat.off) == wr_beat.off - 1'b1);

endmodule

/* vec_exec/vec_alu.sv */
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_alu
    import rvv_isa_pkg::*, vec_pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  alu_beat_t               beat,
    input  logic [`DATA_WIDTH-1:0]  vs1_data,
    input  logic [`DATA_WIDTH-1:0]  vs2_data,
    output wr_beat_t                wr_beat
);

    logic [`DATA_WIDTH-1:0] op_a;
    logic [`DATA_WIDTH-1:0] op_b;
    logic [`DATA_WIDTH-1:0] sum;
    logic [`DATA_WIDTH-1:0] res;
    logic                   sub;
    logic                   carry;
    logic [8:0]             byte_sum;

    assign op_a = beat.use_scalar ? beat.scalar : vs1_data;
    assign op_b = vs2_data;
    assign sub  = beat.funct == VSUB;

    // byte ripple adder, carry restarts at each element boundary
    // b - a as b + ~a + 1
    always_comb begin
        carry = sub;
        sum   = '0;
        for (int i = 0; i < `DW_B; i++) begin
            if ((i & ((1 << beat.sew) - 1)) == 0) carry = sub;
            byte_sum = {1'b0, op_b[i*8 +: 8]} + {1'b0, op_a[i*8 +: 8] ^ {8{sub}}} + 9'(carry);
            sum[i*8 +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

    always_comb begin
        case (beat.funct)
            VAND:    res = op_b & op_a;
            VOR:     res = op_b | op_a;
            VXOR:    res = op_b ^ op_a;
            // vadd, vsub
            default: res = sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_beat.valid <= 1'b0;
        end else begin
            wr_beat.valid <= beat.valid;
        end
        wr_beat.vd   <= beat.vd;
        wr_beat.off  <= beat.off;
        wr_beat.data <= res;
    end

endmodule

/* vec_exec/vec_issue.sv */
`timescale 1ns/1ps
`include "vec_defines.svh"

module vec_issue
    import rvv_isa_pkg::*, vec_pipe_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`INSN_WIDTH-1:0]       insn_in,
    input  logic                         insn_valid,
    input  logic [`XLEN-1:0]             scalar_in,
    output logic                         proc_rdy,
    input  decoded_insn_t                dec,
    output logic [`INSN_WIDTH-1:0]       fetch_insn,
    input  vcfg_t                        cfg,
    output logic                         cfg_fire,
    output logic [`XLEN-1:0]             cfg_scalar,
    output logic [`VREG_ADDR_WIDTH-1:0]  rd_addr_1,
    output logic [`VREG_ADDR_WIDTH-1:0]  rd_addr_2,
    output logic [`VREG_ADDR_WIDTH-1:0]  rd_addr_3,
    output logic [OFF_WIDTH-1:0]         rd_off,
    output alu_beat_t                    alu_beat,
    input  wr_beat_t                     wr_beat,
    input  logic [`DATA_WIDTH-1:0]       st_data,
    output logic [`DATA_WIDTH-1:0]       mem_port_data_out,
    output logic [`MEM_ADDR_WIDTH-1:0]   mem_port_addr_out,
    output logic                         mem_port_valid_out
);

    localparam logic [OFF_WIDTH-1:0] LAST_OFF = OFF_WIDTH'(`BEATS_PER_REG - 1);

    logic                     fetch_valid;
    logic [`XLEN-1:0]         fetch_scalar;
    logic [OFF_WIDTH-1:0]     beat_cnt;
    logic [`NUM_VEC-1:0]      sb;
    logic [`NUM_VEC-1:0]      sb_set;
    logic [`NUM_VEC-1:0]      sb_clr;
    logic                     multi;
    logic                     haz;
    logic                     issue;
    logic                     done;
    logic [`DATA_WIDTH-1:0]   op64;
    logic [`DATA_WIDTH-1:0]   scalar_rep;

    // alu ops and stores walk both beats
    assign multi = dec.cls == CLS_ALU || dec.cls == CLS_STORE;

    // raw check only before beat 0, later beats follow back to back
    assign haz = beat_cnt == '0 && (
                 (dec.cls == CLS_ALU && dec.mnr == IVV && sb[dec.vs1]) ||
                 (dec.cls == CLS_ALU && sb[dec.vs2]) ||
                 (dec.cls == CLS_STORE && sb[dec.vd]));

    assign issue    = fetch_valid && !haz;
    assign done     = issue && (!multi || beat_cnt == LAST_OFF);
    // free once the final beat of a multi-beat insn goes out
    assign proc_rdy = !fetch_valid || (issue && beat_cnt == LAST_OFF);
    assign cfg_fire = issue && beat_cnt == '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            if (insn_valid && proc_rdy) begin
                fetch_valid <= 1'b1;
            end else if (done) begin
                fetch_valid <= 1'b0;
            end
            if (done) begin
                beat_cnt <= '0;
            end else if (issue && multi) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
        if (insn_valid && proc_rdy) begin
            fetch_insn   <= insn_in;
            fetch_scalar <= scalar_in;
        end
    end

    assign cfg_scalar = fetch_scalar;

    // read ports follow the fetched fields
    assign rd_addr_1 = dec.vs1;
    assign rd_addr_2 = dec.vs2;
    assign rd_addr_3 = dec.vd;
    assign rd_off    = beat_cnt;

    // simm5 or rs1, sign extended, then copied into every element
    always_comb begin
        if (dec.mnr == IVI) begin
            op64 = {{(`DATA_WIDTH - 5){dec.vs1[4]}}, dec.vs1};
        end else begin
            op64 = {{(`DATA_WIDTH - `XLEN){fetch_scalar[`XLEN-1]}}, fetch_scalar};
        end
        case (cfg.sew)
            3'd0:    scalar_rep = {`DW_B{op64[7:0]}};
            3'd1:    scalar_rep = {(`DW_B / 2){op64[15:0]}};
            3'd2:    scalar_rep = {(`DW_B / 4){op64[31:0]}};
            default: scalar_rep = op64;
        endcase
    end

    always_comb begin
        alu_beat.valid      = issue && dec.cls == CLS_ALU;
        alu_beat.funct      = dec.funct;
        alu_beat.sew        = cfg.sew;
        alu_beat.vd         = dec.vd;
        alu_beat.off        = beat_cnt;
        alu_beat.use_scalar = dec.mnr != IVV;
        alu_beat.scalar     = scalar_rep;
    end

    // scoreboard: set on beat 0, clear when the final beat lands
    always_comb begin
        sb_set = '0;
        sb_clr = '0;
        if (alu_beat.valid && beat_cnt == '0) sb_set[dec.vd] = 1'b1;
        if (wr_beat.valid && wr_beat.off == LAST_OFF) sb_clr[wr_beat.vd] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sb <= '0;
        end else begin
            // same vd back to back, set wins
            sb <= (sb & ~sb_clr) | sb_set;
        end
    end

    // store beats leave one cycle after the regfile read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_port_valid_out <= 1'b0;
        end else begin
            mem_port_valid_out <= issue && dec.cls == CLS_STORE;
        end
        mem_port_data_out <= st_data;
        mem_port_addr_out <= `MEM_ADDR_WIDTH'(fetch_scalar) +
                             `MEM_ADDR_WIDTH'(beat_cnt) * `MEM_ADDR_WIDTH'(`DW_B);
    end

    // only registers with an op in flight may be written back
    a_wr_tracked: assert property (@(posedge clk) disable iff (!rst_n)
        wr_beat.valid |-> sb[wr_beat.vd]);

endmodule

/* src/rvv_proc_main.sv */
`timescale 1ns/1ps
`include "vec_defines.svh"

module rvv_proc_main
    import rvv_isa_pkg::*, vec_pipe_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`INSN_WIDTH-1:0]      insn_in,
    input  logic                        insn_valid,
    input  logic [`XLEN-1:0]            vexrv_data_in_1,
    output logic                        proc_rdy,
    output logic [`XLEN-1:0]            vexrv_data_out,
    output logic                        vexrv_valid_out,
    output logic [`DATA_WIDTH-1:0]      mem_port_data_out,
    output logic [`MEM_ADDR_WIDTH-1:0]  mem_port_addr_out,
    output logic                        mem_port_valid_out,
    output logic [`DW_B-1:0]            mem_port_be_out
);

    logic [`INSN_WIDTH-1:0]      fetch_insn;
    decoded_insn_t               dec;
    vcfg_t                       cfg;
    logic                        cfg_fire;
    logic [`XLEN-1:0]            cfg_scalar;
    logic [`VREG_ADDR_WIDTH-1:0] rd_addr_1;
    logic [`VREG_ADDR_WIDTH-1:0] rd_addr_2;
    logic [`VREG_ADDR_WIDTH-1:0] rd_addr_3;
    logic [OFF_WIDTH-1:0]        rd_off;
    logic [`DATA_WIDTH-1:0]      rd_data_1;
    logic [`DATA_WIDTH-1:0]      rd_data_2;
    logic [`DATA_WIDTH-1:0]      rd_data_3;
    alu_beat_t                   alu_beat;
    wr_beat_t                    wr_beat;

    vec_issue u_issue (
        .clk(clk), .rst_n(rst_n),
        .insn_in(insn_in), .insn_valid(insn_valid), .scalar_in(vexrv_data_in_1),
        .proc_rdy(proc_rdy), .dec(dec), .fetch_insn(fetch_insn),
        .cfg(cfg), .cfg_fire(cfg_fire), .cfg_scalar(cfg_scalar),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2), .rd_addr_3(rd_addr_3),
        .rd_off(rd_off), .alu_beat(alu_beat), .wr_beat(wr_beat), .st_data(rd_data_3),
        .mem_port_data_out(mem_port_data_out), .mem_port_addr_out(mem_port_addr_out),
        .mem_port_valid_out(mem_port_valid_out)
    );

    insn_decoder u_dec (.insn(fetch_insn), .dec(dec));

    cfg_unit u_cfg (
        .clk(clk), .rst_n(rst_n), .dec(dec), .fire(cfg_fire), .avl(cfg_scalar),
        .cfg(cfg), .vl_report_valid(vexrv_valid_out), .vl_report(vexrv_data_out)
    );

    vec_regfile u_rf (
        .clk(clk), .rst_n(rst_n),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2), .rd_addr_3(rd_addr_3), .rd_off(rd_off),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2), .rd_data_3(rd_data_3),
        .wr_beat(wr_beat)
    );

    vec_alu u_alu (
        .clk(clk), .rst_n(rst_n), .beat(alu_beat),
        .vs1_data(rd_data_1), .vs2_data(rd_data_2), .wr_beat(wr_beat)
    );

    // no masked stores, every byte lane written
    assign mem_port_be_out = '1;

endmodule

/* testbench/tb_rvv_model.svh */
`ifndef TB_RVV_MODEL_SVH
`define TB_RVV_MODEL_SVH

// shadow copy of the vector register file
logic [`VLEN-1:0] shadow [`NUM_VEC];

// 16-bit fibonacci lfsr, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd53634;

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

// one lfsr step per bit
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

// vsetvli with vta set, lmul 1
function automatic logic [31:0] vsetvli_word(input int sew, input logic [4:0] rs1);
    return {1'b0, 3'b000, 1'b0, 1'b1, 3'(sew), 3'b000, rs1, 3'b111, 5'd1, 7'h57};
endfunction

// unmasked op-v arithmetic
function automatic logic [31:0] alu_word(input alu_funct_e funct, input opcode_mnr_e mnr,
                                         input logic [4:0] vd, input logic [4:0] vs2,
                                         input logic [4:0] src);
    return {funct, 1'b1, vs2, src, mnr, vd, V_OP};
endfunction

// unit-stride vse64, base in rs1
function automatic logic [31:0] store_word(input logic [4:0] vs3, input logic [4:0] rs1);
    return {3'b000, 1'b0, 2'b00, 1'b1, 5'b00000, rs1, 3'b111, vs3, ST_OP};
endfunction

// rs1 = x0 gives vlmax, else min of avl and vlmax
function automatic logic [31:0] expected_vl(input int sew, input logic [4:0] rs1,
                                            input logic [31:0] avl);
    logic [31:0] vlmax;
    vlmax = 32'(`VLEN / (8 << sew));
    if (rs1 == 5'd0) return vlmax;
    return (avl < vlmax) ? avl : vlmax;
endfunction

// element-wise op on the shadow registers, result wraps at sew
function automatic void apply_op(input alu_funct_e funct, input opcode_mnr_e mnr,
                                 input int sew, input int vd, input int vs2,
                                 input logic [4:0] src, input logic [31:0] scalar);
    int               ew;
    logic [63:0]      mask;
    logic [63:0]      ea;
    logic [63:0]      eb;
    logic [63:0]      r;
    logic [63:0]      a_sc;
    logic [`VLEN-1:0] res;
    ew   = 8 << sew;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    // simm5 or rs1, both sign extended before truncation
    if (mnr == IVI) a_sc = {{59{src[4]}}, src};
    else a_sc = {{32{scalar[31]}}, scalar};
    res = '0;
    for (int i = 0; i < `VLEN / ew; i++) begin
        eb = 64'(shadow[vs2] >> (i * ew)) & mask;
        ea = (mnr == IVV) ? 64'(shadow[src] >> (i * ew)) : a_sc;
        ea = ea & mask;
        case (funct)
            VADD:    r = eb + ea;
            VSUB:    r = eb - ea;
            VAND:    r = eb & ea;
            VOR:     r = eb | ea;
            default: r = eb ^ ea;
        endcase
        res = res | (`VLEN'(r & mask) << (i * ew));
    end
    shadow[vd] = res;
endfunction

`endif

/* testbench/tb_rvv_proc.sv */
`timescale 1ns/1ps
`include "vec_defines.svh"

module tb_rvv_proc
    import rvv_isa_pkg::*;
;

    localparam int NUM_LOAD    = 8;
    localparam int CHAIN_LEN   = 6;
    localparam int DRAIN_LIMIT = 64;
    // instruction count of every test together
    localparam int N_INSN = 4 * 3 + 3 * NUM_LOAD + 4 * (2 + 15 * 2)
                          + 2 * (1 + CHAIN_LEN + CHAIN_LEN / 2);
    localparam int WATCHDOG_CYCLES = 40 * N_INSN + 200;
    localparam alu_funct_e OPS [5] = '{VADD, VSUB, VAND, VOR, VXOR};
    localparam opcode_mnr_e FORMS [3] = '{IVV, IVX, IVI};

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [`INSN_WIDTH-1:0]     insn_in;
    logic                       insn_valid;
    logic [`XLEN-1:0]           vexrv_data_in_1;
    logic                       proc_rdy;
    logic [`XLEN-1:0]           vexrv_data_out;
    logic                       vexrv_valid_out;
    logic [`DATA_WIDTH-1:0]     mem_port_data_out;
    logic [`MEM_ADDR_WIDTH-1:0] mem_port_addr_out;
    logic                       mem_port_valid_out;
    logic [`DW_B-1:0]           mem_port_be_out;

    // expected outputs, in issue order
    logic [63:0] exp_st_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_vl [$];

    string cur_test = "none";
    int    cur_sew = 0;
    int    n_tests = 0;
    int    n_checks = 0;
    int    n_errors = 0;
    int    err_mark = 0;

    `include "tb_rvv_model.svh"

    rvv_proc_main u_dut (
        .clk(clk), .rst_n(rst_n),
        .insn_in(insn_in), .insn_valid(insn_valid), .vexrv_data_in_1(vexrv_data_in_1),
        .proc_rdy(proc_rdy), .vexrv_data_out(vexrv_data_out),
        .vexrv_valid_out(vexrv_valid_out),
        .mem_port_data_out(mem_port_data_out), .mem_port_addr_out(mem_port_addr_out),
        .mem_port_valid_out(mem_port_valid_out), .mem_port_be_out(mem_port_be_out)
    );

    // 8 ns period
    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        n_checks++;
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            n_errors++;
        end
    endtask

    // entered 1 ns after a rising edge, left 1 ns after the accepting edge
    task automatic send_insn(input logic [31:0] insn, input logic [31:0] scalar);
        bit taken;
        taken           = 1'b0;
        insn_in         = insn;
        vexrv_data_in_1 = scalar;
        insn_valid      = 1'b1;
        // hold until proc_rdy is seen before an edge
        while (!taken) begin
            @(negedge clk);
            taken = proc_rdy;
            @(posedge clk);
            #1;
        end
        insn_valid = 1'b0;
    endtask

    task automatic set_config(input int sew, input logic [4:0] rs1, input logic [31:0] avl);
        exp_vl.push_back(expected_vl(sew, rs1, avl));
        cur_sew = sew;
        send_insn(vsetvli_word(sew, rs1), avl);
    endtask

    task automatic run_alu(input alu_funct_e funct, input opcode_mnr_e mnr, input int vd,
                           input int vs2, input logic [4:0] src, input logic [31:0] scalar);
        apply_op(funct, mnr, cur_sew, vd, vs2, src, scalar);
        send_insn(alu_word(funct, mnr, 5'(vd), 5'(vs2), src), scalar);
    endtask

    // low half at base, high half at base plus one beat
    task automatic store_reg(input int vs3, input logic [31:0] base);
        exp_st_addr.push_back(base);
        exp_st_data.push_back(shadow[vs3][63:0]);
        exp_st_addr.push_back(base + `DW_B);
        exp_st_data.push_back(shadow[vs3][127:64]);
        send_insn(store_word(5'(vs3), 5'd10), base);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = n_errors;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_st_data.size() != 0 || exp_vl.size() != 0) && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_st_data.size() != 0 || exp_vl.size() != 0) begin
            $display("%s: expected store beats or vl reports never arrived", cur_test);
            n_errors++;
            exp_st_data.delete();
            exp_st_addr.delete();
            exp_vl.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test();
        wait_drain();
        if (n_errors == err_mark) $display("test %s: ok", cur_test);
        else $display("test %s: %0d errors", cur_test, n_errors - err_mark);
        n_tests++;
    endtask

    // outputs sampled mid-cycle, away from the edges
    always @(negedge clk) begin : compare_outputs
        logic [31:0] want_addr;
        logic [63:0] want_data;
        logic [31:0] want_vl;
        if (rst_n && mem_port_valid_out) begin
            if (exp_st_data.size() == 0) begin
                $display("%s: store beat at %h with none expected", cur_test, mem_port_addr_out);
                n_errors++;
            end else begin
                want_addr = exp_st_addr.pop_front();
                want_data = exp_st_data.pop_front();
                check_val({cur_test, " store addr"}, 64'(want_addr), 64'(mem_port_addr_out));
                check_val({cur_test, " store data"}, want_data, mem_port_data_out);
                check_val({cur_test, " store be"}, 64'hff, 64'(mem_port_be_out));
            end
        end
        if (rst_n && vexrv_valid_out) begin
            if (exp_vl.size() == 0) begin
                $display("%s: vl report %0d with none expected", cur_test, vexrv_data_out);
                n_errors++;
            end else begin
                want_vl = exp_vl.pop_front();
                check_val({cur_test, " vl"}, 64'(want_vl), 64'(vexrv_data_out));
            end
        end
    end

    // hard stop in case the dut never frees proc_rdy
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int          vlmax;
        int          k;
        int          vd;
        int          vs2;
        int          prev;
        logic [4:0]  src;
        rst_n           = 1'b0;
        insn_in         = '0;
        insn_valid      = 1'b0;
        vexrv_data_in_1 = '0;
        for (int r = 0; r < `NUM_VEC; r++) begin
            shadow[r] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset
        begin_test("reset");
        repeat (3) begin
            @(negedge clk);
            check_val("reset proc_rdy", 64'd1, 64'(proc_rdy));
            check_val("reset vexrv_valid_out", 64'd0, 64'(vexrv_valid_out));
            check_val("reset mem_port_valid_out", 64'd0, 64'(mem_port_valid_out));
        end
        @(posedge clk);
        #1;
        finish_test();

        // x0 source, then avl below and above vlmax
        begin_test("vsetvli");
        for (int s = 0; s < 4; s++) begin
            vlmax = `VLEN / (8 << s);
            set_config(s, 5'd0, take_bits(32));
            set_config(s, 5'd7, take_bits(8) % vlmax);
            set_config(s, 5'd7, vlmax + take_bits(8));
        end
        finish_test();

        // load from v0 plus scalar, then store
        begin_test("vx_store");
        for (int r = 1; r <= NUM_LOAD; r++) begin
            set_config(r % 4, 5'd0, 32'd0);
            run_alu(VADD, IVX, r, 0, 5'd3, take_bits(32));
            store_reg(r, 32'h1000 + 32'(r * 16));
        end
        finish_test();

        // v9 all ones forces wrap on add
        begin_test("all_ops");
        for (int s = 0; s < 4; s++) begin
            set_config(s, 5'd0, 32'd0);
            run_alu(VADD, IVI, 9, 0, 5'h1f, 32'd0);
            k = 0;
            for (int f = 0; f < 5; f++) begin
                for (int m = 0; m < 3; m++) begin
                    vs2 = (k % 4 == 0) ? 9 : 1 + int'(take_bits(3));
                    vd  = 10 + k % 8;
                    if (FORMS[m] == IVI) begin
                        src    = 5'(take_bits(4));
                        // alternate imm sign
                        src[4] = k[0];
                    end else begin
                        src = 5'(1 + take_bits(3));
                    end
                    run_alu(OPS[f], FORMS[m], vd, vs2, src, take_bits(32));
                    store_reg(vd, 32'h2000 + 32'(s * 256 + k * 16));
                    k++;
                end
            end
        end
        finish_test();

        // each op reads the one before, store right behind
        begin_test("hazards");
        for (int c = 0; c < 2; c++) begin
            set_config(c * 2 + 1, 5'd0, 32'd0);
            prev = 1 + c;
            for (int i = 0; i < CHAIN_LEN; i++) begin
                vd = 20 + i % 3;
                if (i % 2 == 0) begin
                    // prior result on vs1
                    run_alu(OPS[i % 5], IVV, vd, 4, 5'(prev), 32'd0);
                end else begin
                    // prior result on vs2
                    run_alu(OPS[i % 5], IVX, vd, prev, 5'd0, take_bits(32));
                    store_reg(vd, 32'h3000 + 32'(c * 256 + i * 16));
                end
                prev = vd;
            end
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+common
+incdir+testbench
common/rvv_isa_pkg.sv
common/vec_pipe_pkg.sv
src/insn_decoder.sv
src/cfg_unit.sv
vec_exec/vec_regfile.sv
vec_exec/vec_alu.sv
vec_exec/vec_issue.sv
src/rvv_proc_main.sv
testbench/tb_rvv_proc.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --assert -Wno-fatal --top-module tb_rvv_proc -f flist.f -o tb_rvv_proc \
    && ./obj_dir/tb_rvv_proc > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }
cat "$LOG"
grep -qF '*** PASSED ***' "$LOG" \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
